// ==== include/mem_stage_consts.svh ====
`ifndef MEM_STAGE_CONSTS_SVH
`define MEM_STAGE_CONSTS_SVH

// data memory geometry, depth in doublewords.
`define MEM_DWORDS      256
`define MEM_ADDR_BITS   8

`define SIZE_NONE       2'd0
`define SIZE_BYTE       2'd1
`define SIZE_WORD       2'd2
`define SIZE_DWORD      2'd3

`define CP0_STATUS      5'd12
`define CP0_CAUSE       5'd13
`define CP0_EPC         5'd14

`define EXC_INT         5'd0
`define EXC_RI          5'd10
`define EXC_OV          5'd12

`define ST_IE           0
`define ST_EXL          1
`define ST_IM_MSB       15
`define ST_IM_LSB       8

`endif

// ==== src/mem_stage_pkg.sv ====
`default_nettype none

package mem_stage_pkg;

    // datum or byte address.
    typedef logic [63:0] dword_t;

    typedef logic [31:0] inst_t;

    // general or coprocessor register number.
    typedef logic [4:0] regnum_t;

    // load and store size code.
    typedef logic [1:0] mem_size_t;

    // one line per interrupt source.
    typedef logic [7:0] irq_t;

    typedef logic [4:0] exc_code_t;

endpackage

`default_nettype wire

// ==== src/data_mem.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "mem_stage_consts.svh"

module data_mem (
    input  logic                   clock,
    input  logic                   reset,
    input  mem_stage_pkg::dword_t    addr,
    input  mem_stage_pkg::dword_t    wdata,
    input  mem_stage_pkg::mem_size_t store_size,
    input  mem_stage_pkg::dword_t    inst_addr,
    output mem_stage_pkg::dword_t    rdata,
    output mem_stage_pkg::inst_t     inst
);

    mem_stage_pkg::dword_t mem [`MEM_DWORDS];

    logic [`MEM_ADDR_BITS-1:0] data_idx;
    logic [`MEM_ADDR_BITS-1:0] inst_idx;
    logic [5:0]                byte_pos;
    mem_stage_pkg::dword_t     inst_dword;

    assign data_idx = addr[`MEM_ADDR_BITS+2:3];
    assign inst_idx = inst_addr[`MEM_ADDR_BITS+2:3];
    assign byte_pos = {addr[2:0], 3'b000};  // bit offset of the byte lane.

    // sized stores, no writes while in reset.
    always_ff @(posedge clock) begin
        if (!reset) begin
            case (store_size)
                `SIZE_BYTE: begin
                    mem[data_idx][byte_pos +: 8] <= wdata[7:0];
                end
                `SIZE_WORD: begin
                    if (addr[2]) begin
                        mem[data_idx][63:32] <= wdata[31:0];
                    end else begin
                        mem[data_idx][31:0] <= wdata[31:0];
                    end
                end
                `SIZE_DWORD: begin
                    mem[data_idx] <= wdata;
                end
                default: begin
                end
            endcase
        end
    end

    assign rdata = mem[data_idx];

    // instruction port shares the array.
    assign inst_dword = mem[inst_idx];
    assign inst       = inst_addr[2] ? inst_dword[63:32] : inst_dword[31:0];

endmodule

`default_nettype wire

// ==== src/load_align.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "mem_stage_consts.svh"

module load_align (
    input  mem_stage_pkg::dword_t    rdata,
    input  logic [2:0]               offset,
    input  mem_stage_pkg::mem_size_t load_size,
    input  logic                     load_signed,
    output mem_stage_pkg::dword_t    load_data
);

    logic [7:0]  byte_lane;
    logic [31:0] word_half;

    assign byte_lane = rdata[{offset, 3'b000} +: 8];
    assign word_half = offset[2] ? rdata[63:32] : rdata[31:0];  // upper half at +4.

    always_comb begin
        case (load_size)
            `SIZE_BYTE: begin
                if (load_signed) begin
                    load_data = {{56{byte_lane[7]}}, byte_lane};
                end else begin
                    load_data = {56'b0, byte_lane};
                end
            end
            `SIZE_WORD: begin
                if (load_signed) begin
                    load_data = {{32{word_half[31]}}, word_half};
                end else begin
                    load_data = {32'b0, word_half};
                end
            end
            `SIZE_DWORD: begin
                load_data = rdata;
            end
            default: begin
                load_data = '0;  // not a load.
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== src/cp0.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "mem_stage_consts.svh"

module cp0 (
    input  logic                     clock,
    input  logic                     reset,
    input  mem_stage_pkg::dword_t    wdata,
    input  mem_stage_pkg::regnum_t   regnum,
    input  mem_stage_pkg::dword_t    next_pc,
    input  logic                     mtc0,
    input  logic                     eret,
    input  logic                     overflow,
    input  logic                     reserved_inst,
    input  mem_stage_pkg::irq_t      interrupt_sources,
    output mem_stage_pkg::dword_t    rdata,
    output mem_stage_pkg::dword_t    epc,
    output logic                     taken_handler
);

    mem_stage_pkg::dword_t     status;
    mem_stage_pkg::dword_t     cause;
    mem_stage_pkg::exc_code_t  exc_code;
    mem_stage_pkg::exc_code_t  next_code;
    logic                      int_pending;

    // pending lines gated by the status mask.
    assign int_pending = |(interrupt_sources & status[`ST_IM_MSB:`ST_IM_LSB]);

    assign taken_handler = overflow || reserved_inst ||
                           (status[`ST_IE] && !status[`ST_EXL] && int_pending);

    always_comb begin
        if (overflow) begin
            next_code = `EXC_OV;
        end else if (reserved_inst) begin
            next_code = `EXC_RI;
        end else begin
            next_code = `EXC_INT;
        end
    end

    // pending bits at 15:8, code at 6:2.
    assign cause = {48'b0, interrupt_sources, 1'b0, exc_code, 2'b00};

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            status   <= '0;
            exc_code <= '0;
            epc      <= '0;
        end else if (taken_handler) begin
            epc              <= next_pc;
            status[`ST_EXL]  <= 1'b1;
            exc_code         <= next_code;
        end else begin
            if (eret) begin
                status[`ST_EXL] <= 1'b0;
            end
            if (mtc0) begin
                case (regnum)
                    `CP0_STATUS: status <= wdata;
                    `CP0_EPC:    epc    <= wdata;
                    default: begin
                    end
                endcase
            end
        end
    end

    // read sees values from before the edge.
    always_comb begin
        case (regnum)
            `CP0_STATUS: rdata = status;
            `CP0_CAUSE:  rdata = cause;
            `CP0_EPC:    rdata = epc;
            default:     rdata = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== src/mem_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "mem_stage_consts.svh"

module mem_stage (
    input  logic                     clock,
    input  logic                     reset,
    input  mem_stage_pkg::dword_t    alu_out,
    input  mem_stage_pkg::dword_t    b_data,
    input  mem_stage_pkg::dword_t    pc4,
    input  mem_stage_pkg::dword_t    next_pc,
    input  mem_stage_pkg::dword_t    inst_addr,
    input  mem_stage_pkg::dword_t    d_rdata,
    input  mem_stage_pkg::regnum_t   w_regnum,
    input  mem_stage_pkg::mem_size_t mem_store_type,
    input  mem_stage_pkg::mem_size_t mem_load_type,
    input  logic                     load_signed,
    input  logic                     write_enable,
    input  logic                     mtc0,
    input  logic                     mfc0,
    input  logic                     eret,
    input  logic                     overflow,
    input  logic                     reserved_inst,
    input  logic                     linkpc,
    input  logic                     d_valid,
    input  logic                     d_ready,
    input  mem_stage_pkg::irq_t      interrupt_sources,
    output mem_stage_pkg::inst_t     inst,
    output mem_stage_pkg::dword_t    w_data,
    output mem_stage_pkg::dword_t    epc_q,
    output mem_stage_pkg::regnum_t   w_regnum_q,
    output logic                     write_enable_q,
    output logic                     taken_handler_q
);

    mem_stage_pkg::mem_size_t store_size;
    mem_stage_pkg::dword_t    rdata;
    mem_stage_pkg::dword_t    load_data;
    mem_stage_pkg::dword_t    c0_rdata;
    mem_stage_pkg::dword_t    epc;
    mem_stage_pkg::dword_t    wb_data;
    logic                     taken_handler;

    // external bus owns the access.
    assign store_size = (d_valid || d_ready) ? `SIZE_NONE : mem_store_type;

    data_mem data_mem_inst (
        .clock      (clock),
        .reset      (reset),
        .addr       (alu_out),
        .wdata      (b_data),
        .store_size (store_size),
        .inst_addr  (inst_addr),
        .rdata      (rdata),
        .inst       (inst)
    );

    load_align load_align_inst (
        .rdata       (rdata),
        .offset      (alu_out[2:0]),
        .load_size   (mem_load_type),
        .load_signed (load_signed),
        .load_data   (load_data)
    );

    cp0 cp0_inst (
        .clock             (clock),
        .reset             (reset),
        .wdata             (b_data),
        .regnum            (w_regnum),
        .next_pc           (next_pc),
        .mtc0              (mtc0),
        .eret              (eret),
        .overflow          (overflow),
        .reserved_inst     (reserved_inst),
        .interrupt_sources (interrupt_sources),
        .rdata             (c0_rdata),
        .epc               (epc),
        .taken_handler     (taken_handler)
    );

    // writeback source, link first.
    always_comb begin
        if (linkpc) begin
            wb_data = pc4;
        end else if (mfc0) begin
            wb_data = c0_rdata;
        end else if (d_valid) begin
            wb_data = d_rdata;
        end else if (mem_load_type != `SIZE_NONE) begin
            wb_data = load_data;
        end else begin
            wb_data = alu_out;
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            w_data          <= '0;
            epc_q           <= '0;
            w_regnum_q      <= '0;
            write_enable_q  <= 1'b0;
            taken_handler_q <= 1'b0;
        end else begin
            w_data          <= wb_data;
            epc_q           <= epc;
            w_regnum_q      <= w_regnum;
            write_enable_q  <= write_enable;
            taken_handler_q <= taken_handler;
        end
    end

endmodule

`default_nettype wire

// ==== sim/mem_stage_chk.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "mem_stage_consts.svh"

module mem_stage_chk (
    input  logic                     clock,
    input  logic                     reset,
    input  logic                     d_valid,
    input  logic                     d_ready,
    input  logic                     mtc0,
    input  mem_stage_pkg::regnum_t   w_regnum,
    input  mem_stage_pkg::dword_t    alu_out,
    input  mem_stage_pkg::dword_t    rdata,
    input  mem_stage_pkg::dword_t    w_data,
    input  mem_stage_pkg::dword_t    epc_q,
    input  mem_stage_pkg::regnum_t   w_regnum_q,
    input  logic                     write_enable_q,
    input  logic                     taken_handler_q
);

    reset_clears_outputs: assert property (@(posedge clock)
        reset |-> (w_data == '0 && epc_q == '0 && w_regnum_q == '0 &&
                   !write_enable_q && !taken_handler_q))
        else $error("registered outputs not clear during reset");

    // a bus cycle leaves the addressed entry as it was.
    no_store_on_bus: assert property (@(posedge clock) disable iff (reset)
        ($past(d_valid || d_ready) &&
         alu_out[`MEM_ADDR_BITS+2:3] == $past(alu_out[`MEM_ADDR_BITS+2:3])) |->
            rdata == $past(rdata))
        else $error("local store reached data memory during a bus access");

    // epc_q trails the cp0 register by one cycle.
    epc_write_source: assert property (@(posedge clock) disable iff (reset)
        (epc_q != $past(epc_q)) |->
            ($past(taken_handler_q) || $past(mtc0 && w_regnum == `CP0_EPC, 2)))
        else $error("epc_q changed without a handler entry or an EPC write");

endmodule

`default_nettype wire

// ==== sim/mem_stage_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "mem_stage_consts.svh"

module mem_stage_tb;

    localparam int RANDOM_CYCLES = 4000;
    localparam int LIMIT_CYCLES  = RANDOM_CYCLES + `MEM_DWORDS + 100;

    logic                     clock;
    logic                     reset;
    mem_stage_pkg::dword_t    alu_out, b_data, pc4, next_pc, inst_addr, d_rdata;
    mem_stage_pkg::regnum_t   w_regnum;
    mem_stage_pkg::mem_size_t mem_store_type, mem_load_type;
    logic                     load_signed, write_enable, mtc0, mfc0, eret;
    logic                     overflow, reserved_inst, linkpc, d_valid, d_ready;
    mem_stage_pkg::irq_t      interrupt_sources;
    mem_stage_pkg::inst_t     inst;
    mem_stage_pkg::dword_t    w_data, epc_q;
    mem_stage_pkg::regnum_t   w_regnum_q;
    logic                     write_enable_q, taken_handler_q;

    // reference model state.
    mem_stage_pkg::dword_t    model_mem [`MEM_DWORDS];
    mem_stage_pkg::dword_t    m_status, m_epc;
    mem_stage_pkg::exc_code_t m_code;
    mem_stage_pkg::dword_t    exp_w_data, exp_epc_q;
    mem_stage_pkg::regnum_t   exp_regnum;
    logic                     exp_we, exp_taken;

    logic [31:0] seed;
    int          check_count;
    int          error_count;
    string       phase;

    mem_stage mem_stage_inst (.*);

    bind mem_stage mem_stage_chk mem_stage_chk_inst (.*);

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    initial begin
        #(LIMIT_CYCLES * 40);
        $display("simulation timed out, checks %0d, errors %0d", check_count, error_count);
        $display("Regression failed");
        $finish;
    end

    // upper halves of two LCG steps.
    function automatic logic [31:0] next_rand();
        logic [15:0] hi;
        seed = seed * 32'd1664525 + 32'd1013904223;
        hi   = seed[31:16];
        seed = seed * 32'd1664525 + 32'd1013904223;
        return {hi, seed[31:16]};
    endfunction

    function automatic mem_stage_pkg::dword_t rand64();
        logic [31:0] hi;
        logic [31:0] lo;
        hi = next_rand();
        lo = next_rand();
        return {hi, lo};
    endfunction

    function automatic mem_stage_pkg::dword_t fill_pattern(input mem_stage_pkg::dword_t addr);
        return (addr * 64'h9e37_79b9_7f4a_7c15) ^ {addr[31:0], ~addr[31:0]};
    endfunction

    task automatic compare(input string name, input mem_stage_pkg::dword_t expected,
                           input mem_stage_pkg::dword_t actual);
        check_count++;
        assert (actual === expected) else begin
            error_count++;
            $display("Fail %s %s: expected %h, actual %h", phase, name, expected, actual);
        end
    endtask

    task automatic check_outputs();
        compare("w_data", exp_w_data, w_data);
        compare("epc_q", exp_epc_q, epc_q);
        compare("w_regnum_q", 64'(exp_regnum), 64'(w_regnum_q));
        compare("write_enable_q", 64'(exp_we), 64'(write_enable_q));
        compare("taken_handler_q", 64'(exp_taken), 64'(taken_handler_q));
    endtask

    task automatic clear_inputs();
        {alu_out, b_data, pc4, next_pc, inst_addr, d_rdata} = '0;
        {w_regnum, mem_store_type, mem_load_type, interrupt_sources} = '0;
        {load_signed, write_enable, mtc0, mfc0, eret, overflow} = '0;
        {reserved_inst, linkpc, d_valid, d_ready} = '0;
    endtask

    task automatic randomize_inputs();
        logic [31:0] r1;
        logic [31:0] r2;
        r1 = next_rand();
        r2 = next_rand();
        alu_out = rand64();
        if (r1[0]) begin
            alu_out[`MEM_ADDR_BITS+2:3] = '0;  // crowd into a few entries.
            alu_out[5:3] = r1[3:1];
        end
        b_data         = rand64();
        pc4            = rand64();
        next_pc        = rand64();
        inst_addr      = rand64();
        d_rdata        = rand64();
        mem_store_type = r1[5:4];
        mem_load_type  = r1[7:6];
        load_signed    = r1[8];
        write_enable   = r1[9];
        w_regnum       = (r1[11:10] == 2'd0) ? r1[16:12] : 5'd11 + {3'b0, r1[11:10]};
        mtc0           = (r1[19:17] == 3'd0);
        mfc0           = (r1[22:20] == 3'd0);
        eret           = (r1[26:23] == 4'd0);
        linkpc         = (r1[30:27] == 4'd0);
        overflow       = (r2[4:0] == 5'd0);
        reserved_inst  = (r2[9:5] == 5'd0);
        d_valid        = (r2[12:10] == 3'd0);
        d_ready        = (r2[15:13] == 3'd0);
        interrupt_sources = (r2[17:16] == 2'd0) ? r2[31:24] : 8'd0;
    endtask

    // expected outputs for the coming edge, then the model update.
    task automatic model_step();
        logic [`MEM_ADDR_BITS-1:0] idx;
        logic [2:0]                off;
        mem_stage_pkg::dword_t     word, lane, loaded, c0_read;
        logic [31:0]               half;
        logic                      taken;
        idx  = alu_out[`MEM_ADDR_BITS+2:3];
        off  = alu_out[2:0];
        word = model_mem[idx];
        lane = word >> {off, 3'b000};
        half = alu_out[2] ? word[63:32] : word[31:0];
        if (mem_load_type == `SIZE_BYTE) begin
            loaded = load_signed ? {{56{lane[7]}}, lane[7:0]} : {56'b0, lane[7:0]};
        end else if (mem_load_type == `SIZE_WORD) begin
            loaded = load_signed ? {{32{half[31]}}, half} : {32'b0, half};
        end else begin
            loaded = word;
        end
        if (w_regnum == `CP0_STATUS) begin
            c0_read = m_status;
        end else if (w_regnum == `CP0_CAUSE) begin
            c0_read = {48'b0, interrupt_sources, 1'b0, m_code, 2'b00};
        end else if (w_regnum == `CP0_EPC) begin
            c0_read = m_epc;
        end else begin
            c0_read = '0;
        end
        taken = overflow || reserved_inst || (m_status[`ST_IE] && !m_status[`ST_EXL] &&
                (|(interrupt_sources & m_status[`ST_IM_MSB:`ST_IM_LSB])));
        if (linkpc) begin
            exp_w_data = pc4;
        end else if (mfc0) begin
            exp_w_data = c0_read;
        end else if (d_valid) begin
            exp_w_data = d_rdata;
        end else if (mem_load_type != `SIZE_NONE) begin
            exp_w_data = loaded;
        end else begin
            exp_w_data = alu_out;
        end
        exp_epc_q  = m_epc;
        exp_regnum = w_regnum;
        exp_we     = write_enable;
        exp_taken  = taken;
        if (!d_valid && !d_ready) begin
            if (mem_store_type == `SIZE_BYTE) begin
                model_mem[idx][{off, 3'b000} +: 8] = b_data[7:0];
            end else if (mem_store_type == `SIZE_WORD && alu_out[2]) begin
                model_mem[idx][63:32] = b_data[31:0];
            end else if (mem_store_type == `SIZE_WORD) begin
                model_mem[idx][31:0] = b_data[31:0];
            end else if (mem_store_type == `SIZE_DWORD) begin
                model_mem[idx] = b_data;
            end
        end
        if (taken) begin
            m_epc            = next_pc;
            m_status[`ST_EXL] = 1'b1;
            m_code = overflow ? `EXC_OV : (reserved_inst ? `EXC_RI : `EXC_INT);
        end else begin
            if (eret) begin
                m_status[`ST_EXL] = 1'b0;
            end
            if (mtc0 && w_regnum == `CP0_STATUS) begin
                m_status = b_data;
            end
            if (mtc0 && w_regnum == `CP0_EPC) begin
                m_epc = b_data;
            end
        end
    endtask

    // called right after inputs change on a falling edge.
    task automatic finish_cycle(input logic inst_known);
        logic [`MEM_ADDR_BITS-1:0] idx;
        mem_stage_pkg::inst_t      exp_inst;
        #5;
        if (inst_known) begin
            idx      = inst_addr[`MEM_ADDR_BITS+2:3];
            exp_inst = inst_addr[2] ? model_mem[idx][63:32] : model_mem[idx][31:0];
            compare("inst", 64'(exp_inst), 64'(inst));
        end
        model_step();
        @(negedge clock);
        check_outputs();
    endtask

    initial begin
        seed        = 32'he9ae;
        check_count = 0;
        error_count = 0;
        phase       = "reset";
        reset       = 1'b1;
        clear_inputs();
        {exp_w_data, exp_epc_q, exp_regnum, exp_we, exp_taken} = '0;
        {m_status, m_epc, m_code} = '0;
        repeat (10) @(negedge clock);
        check_outputs();
        reset = 1'b0;
        phase = "fill";
        for (int i = 0; i < `MEM_DWORDS; i++) begin
            clear_inputs();
            alu_out        = 64'(i) << 3;
            b_data         = fill_pattern(alu_out);
            mem_store_type = `SIZE_DWORD;
            w_regnum       = i[4:0];
            write_enable   = i[0];
            finish_cycle(1'b0);
        end
        phase = "random";
        for (int n = 0; n < RANDOM_CYCLES; n++) begin
            randomize_inputs();
            finish_cycle(1'b1);
        end
        $display("checks %0d, errors %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== all.f ====
+incdir+include
src/mem_stage_pkg.sv
src/data_mem.sv
src/load_align.sv
src/cp0.sv
src/mem_stage.sv
sim/mem_stage_chk.sv
sim/mem_stage_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the mem_stage testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f all.f --top-module mem_stage_tb \
    -o mem_stage_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/mem_stage_sim > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if grep -q "Regression failed" sim.log; then
    exit 1
fi
exit 0
